// ==== alu_pkg.sv ====
package alu_pkg;

  // ALU operation codes
  localparam logic [3:0] op_zero   = 4'h0;
  localparam logic [3:0] op_load_a = 4'h1;
  localparam logic [3:0] op_inc    = 4'h2;
  localparam logic [3:0] op_dec    = 4'h3;
  localparam logic [3:0] op_asl    = 4'h4;  // ops 4..7 and 12..15 update carry
  localparam logic [3:0] op_lsr    = 4'h5;
  localparam logic [3:0] op_rol    = 4'h6;
  localparam logic [3:0] op_ror    = 4'h7;
  localparam logic [3:0] op_or     = 4'h8;
  localparam logic [3:0] op_and    = 4'h9;
  localparam logic [3:0] op_xor    = 4'ha;
  localparam logic [3:0] op_load_b = 4'hb;
  localparam logic [3:0] op_add    = 4'hc;
  localparam logic [3:0] op_sub    = 4'hd;
  localparam logic [3:0] op_adc    = 4'he;
  localparam logic [3:0] op_sbb    = 4'hf;

  localparam logic [1:0] imm_tag   = 2'b11;     // 11+++aaa ########
  localparam logic [4:0] reg_major = 5'b00000;  // 00000aaa 0++++bbb

  typedef union packed {
    struct packed {
      logic [4:0] major;
      logic [2:0] dest;
      logic       mbz;   // must be zero
      logic [3:0] op;
      logic [2:0] src;   // source register, ignored here
    } rf;
    struct packed {
      logic [1:0] tag;   // low bit doubles as op bit 3
      logic [2:0] op;
      logic [2:0] dest;
      logic [7:0] imm;
    } im;
  } instr_word_t;

  function automatic logic is_imm(instr_word_t w);
    return w.im.tag == imm_tag;
  endfunction

  function automatic logic is_reg(instr_word_t w);
    return (w.rf.major == reg_major) && !w.rf.mbz;
  endfunction

endpackage

// ==== lane_if.sv ====
`timescale 1ns/1ns

// one lane's issue and drain handshakes
interface lane_if #(
  parameter int WIDTH = 16
);

  // issue side
  logic             cmd_req;
  logic [3:0]       cmd_op;
  logic [WIDTH-1:0] cmd_a;
  logic [WIDTH-1:0] cmd_b;
  logic             cmd_carry;
  logic [2:0]       cmd_dest;
  logic             cmd_ack;

  // drain side
  logic             res_req;
  logic [WIDTH-1:0] res_y;
  logic             res_carry;
  logic             res_zero;
  logic             res_neg;
  logic [2:0]       res_dest;
  logic             res_ack;

  modport issuer (
    output cmd_req, cmd_op, cmd_a, cmd_b, cmd_carry, cmd_dest,
    input  cmd_ack
  );

  modport lane (
    input  cmd_req, cmd_op, cmd_a, cmd_b, cmd_carry, cmd_dest, res_ack,
    output cmd_ack, res_req, res_y, res_carry, res_zero, res_neg, res_dest
  );

  modport drainer (
    input  res_req, res_y, res_carry, res_zero, res_neg, res_dest,
    output res_ack
  );

endinterface

// ==== alu_dispatch.sv ====
`timescale 1ns/1ns

module alu_dispatch import alu_pkg::*; #(
  parameter int NUM_LANES = 4,
  parameter int WIDTH     = 16
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             in_req,
  input  instr_word_t      in_instr,
  input  logic [WIDTH-1:0] in_a,
  input  logic [WIDTH-1:0] in_b,
  input  logic             in_carry,
  output logic             in_ack,
  lane_if.issuer           lanes [NUM_LANES]
);

  localparam int PTR_W = $clog2(NUM_LANES);

  localparam logic [2:0] s_idle      = 3'd0;
  localparam logic [2:0] s_decode    = 3'd1;
  localparam logic [2:0] s_issue     = 3'd2;
  localparam logic [2:0] s_lane_done = 3'd3;
  localparam logic [2:0] s_in_done   = 3'd4;

  logic [2:0]       state;
  logic [PTR_W-1:0] issue_ptr;
  logic             cmd_req_q;
  logic [NUM_LANES-1:0] ack_vec;
  logic             cur_ack;

  // decoded command
  logic             dec_legal;
  logic [3:0]       dec_op;
  logic [2:0]       dec_dest;
  logic [WIDTH-1:0] dec_b;

  // held command
  logic             legal_q;
  logic [3:0]       op_q;
  logic [2:0]       dest_q;
  logic [WIDTH-1:0] a_q;
  logic [WIDTH-1:0] b_q;
  logic             carry_q;

  always_comb begin
    dec_legal = 1'b1;
    dec_op    = in_instr.rf.op;
    dec_dest  = in_instr.rf.dest;
    dec_b     = in_b;
    if (is_imm(in_instr)) begin
      dec_op   = {in_instr.im.tag[0], in_instr.im.op};  // bits 14:11
      dec_dest = in_instr.im.dest;
      dec_b    = WIDTH'(in_instr.im.imm);               // zero-extended
    end else if (!is_reg(in_instr)) begin
      dec_legal = 1'b0;  // neither form, drop it
    end
  end

  always_ff @(posedge clk) begin
    if (state == s_idle && in_req) begin
      legal_q <= dec_legal;
      op_q    <= dec_op;
      dest_q  <= dec_dest;
      a_q     <= in_a;
      b_q     <= dec_b;
      carry_q <= in_carry;
    end
  end

  // fan the held command out, req only to the selected lane
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    assign lanes[i].cmd_req   = cmd_req_q && (issue_ptr == PTR_W'(i));
    assign lanes[i].cmd_op    = op_q;
    assign lanes[i].cmd_a     = a_q;
    assign lanes[i].cmd_b     = b_q;
    assign lanes[i].cmd_carry = carry_q;
    assign lanes[i].cmd_dest  = dest_q;
    assign ack_vec[i]         = lanes[i].cmd_ack;
  end

  assign cur_ack = ack_vec[issue_ptr];

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= s_idle;
      issue_ptr <= '0;
      cmd_req_q <= 1'b0;
      in_ack    <= 1'b0;
    end else begin
      case (state)
        s_idle:
          if (in_req) state <= s_decode;
        s_decode:
          if (legal_q) begin
            cmd_req_q <= 1'b1;
            state     <= s_issue;
          end else begin
            in_ack <= 1'b1;  // illegal word, ack only
            state  <= s_in_done;
          end
        s_issue:
          if (cur_ack) begin
            cmd_req_q <= 1'b0;
            in_ack    <= 1'b1;
            state     <= s_lane_done;
          end
        s_lane_done:
          if (!cur_ack) begin  // lane side complete
            issue_ptr <= (issue_ptr == PTR_W'(NUM_LANES - 1)) ? '0 : issue_ptr + 1'b1;
            state     <= s_in_done;
          end
        s_in_done:
          if (!in_req) begin
            in_ack <= 1'b0;
            state  <= s_idle;
          end
        default: state <= s_idle;
      endcase
    end
  end

endmodule

// ==== alu_lane.sv ====
`timescale 1ns/1ns

module alu_lane import alu_pkg::*; #(
  parameter int WIDTH = 16
) (
  input  logic clk,
  input  logic reset,
  lane_if.lane port
);

  localparam logic [1:0] s_empty   = 2'd0;
  localparam logic [1:0] s_loaded  = 2'd1;  // cmd_ack high
  localparam logic [1:0] s_result  = 2'd2;  // res_req high
  localparam logic [1:0] s_release = 2'd3;

  logic [1:0]       state;
  logic [3:0]       op_q;
  logic [WIDTH-1:0] a_q;
  logic [WIDTH-1:0] b_q;
  logic             carry_q;
  logic [2:0]       dest_q;

  logic [WIDTH:0]   a_x;
  logic [WIDTH:0]   b_x;
  logic [WIDTH:0]   y;  // result plus extra bit
  logic             y_carry;

  assign a_x = {1'b0, a_q};
  assign b_x = {1'b0, b_q};

  always_comb begin
    case (op_q)
      op_zero:   y = '0;
      op_load_a: y = a_x;
      op_inc:    y = a_x + 1'b1;
      op_dec:    y = a_x - 1'b1;
      op_asl:    y = {a_q, 1'b0};
      op_lsr:    y = {a_q[0], 1'b0, a_q[WIDTH-1:1]};
      op_rol:    y = {a_q, carry_q};
      op_ror:    y = {a_q[0], carry_q, a_q[WIDTH-1:1]};
      op_or:     y = a_x | b_x;
      op_and:    y = a_x & b_x;
      op_xor:    y = a_x ^ b_x;
      op_load_b: y = b_x;
      op_add:    y = a_x + b_x;
      op_sub:    y = a_x - b_x;
      op_adc:    y = a_x + b_x + {{WIDTH{1'b0}}, carry_q};
      op_sbb:    y = a_x - b_x - {{WIDTH{1'b0}}, carry_q};
      default:   y = '0;
    endcase
  end

  // only shift, rotate and add/sub groups touch carry
  assign y_carry = op_q[2] ? y[WIDTH] : carry_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= s_empty;
    end else begin
      case (state)
        s_empty:   if (port.cmd_req) state <= s_loaded;
        s_loaded:  if (!port.cmd_req) state <= s_result;
        s_result:  if (port.res_ack) state <= s_release;
        s_release: if (!port.res_ack) state <= s_empty;
        default:   state <= s_empty;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == s_empty && port.cmd_req) begin
      op_q    <= port.cmd_op;
      a_q     <= port.cmd_a;
      b_q     <= port.cmd_b;
      carry_q <= port.cmd_carry;
      dest_q  <= port.cmd_dest;
    end
    if (state == s_loaded && !port.cmd_req) begin
      port.res_y     <= y[WIDTH-1:0];
      port.res_carry <= y_carry;
      port.res_zero  <= ~|y[WIDTH-1:0];
      port.res_neg   <= y[WIDTH-1];
    end
  end

  assign port.cmd_ack  = (state == s_loaded);
  assign port.res_req  = (state == s_result);
  assign port.res_dest = dest_q;  // held until next command

endmodule

// ==== alu_collect.sv ====
`timescale 1ns/1ns

module alu_collect #(
  parameter int NUM_LANES = 4,
  parameter int WIDTH     = 16
) (
  input  logic             clk,
  input  logic             reset,
  lane_if.drainer          lanes [NUM_LANES],
  output logic             out_req,
  output logic [WIDTH-1:0] out_y,
  output logic             out_carry,
  output logic             out_zero,
  output logic             out_neg,
  output logic [2:0]       out_dest,
  input  logic             out_ack
);

  localparam int PTR_W = $clog2(NUM_LANES);

  localparam logic [1:0] s_wait    = 2'd0;
  localparam logic [1:0] s_present = 2'd1;  // out_req high
  localparam logic [1:0] s_release = 2'd2;  // waiting for out_ack low

  logic [1:0]           state;
  logic [PTR_W-1:0]     drain_ptr;
  logic                 res_ack_q;
  logic                 take;

  logic [NUM_LANES-1:0] req_vec;
  logic [NUM_LANES-1:0] carry_vec;
  logic [NUM_LANES-1:0] zero_vec;
  logic [NUM_LANES-1:0] neg_vec;
  logic [WIDTH-1:0]     y_arr    [NUM_LANES];
  logic [2:0]           dest_arr [NUM_LANES];

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    assign req_vec[i]     = lanes[i].res_req;
    assign y_arr[i]       = lanes[i].res_y;
    assign carry_vec[i]   = lanes[i].res_carry;
    assign zero_vec[i]    = lanes[i].res_zero;
    assign neg_vec[i]     = lanes[i].res_neg;
    assign dest_arr[i]    = lanes[i].res_dest;
    assign lanes[i].res_ack = res_ack_q && (drain_ptr == PTR_W'(i));
  end

  assign take = (state == s_wait) && req_vec[drain_ptr];

  always_ff @(posedge clk) begin
    if (take) begin
      out_y     <= y_arr[drain_ptr];
      out_carry <= carry_vec[drain_ptr];
      out_zero  <= zero_vec[drain_ptr];
      out_neg   <= neg_vec[drain_ptr];
      out_dest  <= dest_arr[drain_ptr];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= s_wait;
      drain_ptr <= '0;
      res_ack_q <= 1'b0;
      out_req   <= 1'b0;
    end else begin
      // lane handshake finishes on its own while out_req is pending
      if (res_ack_q && !req_vec[drain_ptr]) res_ack_q <= 1'b0;
      case (state)
        s_wait:
          if (take) begin
            res_ack_q <= 1'b1;
            out_req   <= 1'b1;
            state     <= s_present;
          end
        s_present:
          if (out_ack) begin
            out_req <= 1'b0;
            state   <= s_release;
          end
        s_release:
          if (!out_ack && !res_ack_q) begin
            drain_ptr <= (drain_ptr == PTR_W'(NUM_LANES - 1)) ? '0 : drain_ptr + 1'b1;
            state     <= s_wait;
          end
        default: state <= s_wait;
      endcase
    end
  end

endmodule

// ==== alu_array_top.sv ====
`timescale 1ns/1ns

module alu_array_top #(
  parameter int NUM_LANES = 4,
  parameter int WIDTH     = 16
) (
  input  logic             clk,
  input  logic             reset,
  // command port
  input  logic             in_req,
  input  logic [15:0]      in_instr,
  input  logic [WIDTH-1:0] in_a,
  input  logic [WIDTH-1:0] in_b,
  input  logic             in_carry,
  output logic             in_ack,
  // result port
  output logic             out_req,
  output logic [WIDTH-1:0] out_y,
  output logic             out_carry,
  output logic             out_zero,
  output logic             out_neg,
  output logic [2:0]       out_dest,
  input  logic             out_ack
);

  lane_if #(.WIDTH(WIDTH)) lanes [NUM_LANES] ();

  alu_dispatch #(
    .NUM_LANES(NUM_LANES),
    .WIDTH    (WIDTH)
  ) u_dispatch (
    .clk     (clk),
    .reset   (reset),
    .in_req  (in_req),
    .in_instr(in_instr),
    .in_a    (in_a),
    .in_b    (in_b),
    .in_carry(in_carry),
    .in_ack  (in_ack),
    .lanes   (lanes)
  );

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    alu_lane #(.WIDTH(WIDTH)) u_lane (
      .clk  (clk),
      .reset(reset),
      .port (lanes[i])
    );
  end

  alu_collect #(
    .NUM_LANES(NUM_LANES),
    .WIDTH    (WIDTH)
  ) u_collect (
    .clk      (clk),
    .reset    (reset),
    .lanes    (lanes),
    .out_req  (out_req),
    .out_y    (out_y),
    .out_carry(out_carry),
    .out_zero (out_zero),
    .out_neg  (out_neg),
    .out_dest (out_dest),
    .out_ack  (out_ack)
  );

endmodule

// ==== alu_array_properties.sv ====
`timescale 1ns/1ns

module alu_array_properties #(
  parameter int WIDTH = 16
) (
  input logic             clk,
  input logic             reset,
  input logic             in_req,
  input logic             in_ack,
  input logic             out_req,
  input logic [WIDTH-1:0] out_y,
  input logic             out_carry,
  input logic             out_zero,
  input logic             out_neg,
  input logic [2:0]       out_dest,
  input logic             out_ack
);

  // both ports quiet once reset is seen
  a_quiet_after_reset: assert property (@(posedge clk) reset |=> !out_req && !in_ack)
    else $error("out_req or in_ack high in the cycle after reset");

  a_result_stable: assert property (@(posedge clk) disable iff (reset)
    (out_req && !out_ack) |=> $stable({out_y, out_carry, out_zero, out_neg, out_dest}))
    else $error("result changed while out_req high and out_ack low");

  a_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
    $rose(in_ack) |-> in_req)
    else $error("in_ack rose while in_req low");

  // out_req held until the receiver acks
  a_req_held: assert property (@(posedge clk) disable iff (reset)
    (out_req && !out_ack) |=> out_req)
    else $error("out_req fell before out_ack rose");

endmodule

bind alu_array_top alu_array_properties #(.WIDTH(WIDTH)) u_props (
  .clk      (clk),
  .reset    (reset),
  .in_req   (in_req),
  .in_ack   (in_ack),
  .out_req  (out_req),
  .out_y    (out_y),
  .out_carry(out_carry),
  .out_zero (out_zero),
  .out_neg  (out_neg),
  .out_dest (out_dest),
  .out_ack  (out_ack)
);

// ==== tb_alu_array.sv ====
`timescale 1ns/1ns

module tb_alu_array import alu_pkg::*; ();

  localparam int NUM_LANES   = 4;
  localparam int WIDTH       = 16;
  localparam int NUM_CMDS    = 400;
  localparam int CYCLE_LIMIT = NUM_CMDS * 40 + 200;

  logic             clk;
  logic             reset;
  logic             in_req;
  logic [15:0]      in_instr;
  logic [WIDTH-1:0] in_a;
  logic [WIDTH-1:0] in_b;
  logic             in_carry;
  logic             in_ack;
  logic             out_req;
  logic [WIDTH-1:0] out_y;
  logic             out_carry;
  logic             out_zero;
  logic             out_neg;
  logic [2:0]       out_dest;
  logic             out_ack;

  logic [31:0]      stim_state = 32'd60418;
  logic [31:0]      ack_state  = 32'd60418;  // separate stream for out_ack delays
  int               cycles     = 0;

  // expected results with one entry per legal command
  logic [WIDTH-1:0] exp_y_q [$];
  logic [2:0]       exp_flags_q [$];  // {carry, zero, neg}
  logic [2:0]       exp_dest_q [$];
  string            name_q [$];

  alu_array_top #(
    .NUM_LANES(NUM_LANES),
    .WIDTH    (WIDTH)
  ) dut (
    .clk(clk), .reset(reset),
    .in_req(in_req), .in_instr(in_instr), .in_a(in_a), .in_b(in_b),
    .in_carry(in_carry), .in_ack(in_ack),
    .out_req(out_req), .out_y(out_y), .out_carry(out_carry), .out_zero(out_zero),
    .out_neg(out_neg), .out_dest(out_dest), .out_ack(out_ack)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [15:0] lcg_next(inout logic [31:0] state);
    state = state * 32'd1664525 + 32'd1013904223;
    return state[30:15];  // low bits of an LCG cycle too fast
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [WIDTH-1:0] expected,
                             input logic [WIDTH-1:0] actual);
    if (actual !== expected)
      stop_with_failure($sformatf("FAILED %s value expected %h actual %h",
                                  name, expected, actual));
  endtask

  task automatic check_flags(input string name, input logic [2:0] expected,
                             input logic [2:0] actual);
    if (actual !== expected)
      stop_with_failure($sformatf("FAILED %s flags czn expected %b actual %b",
                                  name, expected, actual));
  endtask

  task automatic check_dest(input string name, input logic [2:0] expected,
                            input logic [2:0] actual);
    if (actual !== expected)
      stop_with_failure($sformatf("FAILED %s dest expected %0d actual %0d",
                                  name, expected, actual));
  endtask

  // reference ALU in integer arithmetic
  task automatic push_expected(input string name, input logic [3:0] op,
                               input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b,
                               input logic cin, input logic [2:0] dest);
    int               ia;
    int               ib;
    int               ic;
    int               full;
    logic [WIDTH-1:0] low;
    logic             xbit;
    logic             carry_out;
    ia   = int'(a);
    ib   = int'(b);
    ic   = int'(cin);
    full = 0;
    case (op)
      op_zero:   full = 0;
      op_load_a: full = ia;
      op_inc:    full = ia + 1;
      op_dec:    full = ia - 1;
      op_asl:    full = ia * 2;
      op_lsr:    full = ia / 2;
      op_rol:    full = ia * 2 + ic;
      op_ror:    full = ia / 2 + ic * (1 << (WIDTH - 1));
      op_or:     full = int'(a | b);
      op_and:    full = int'(a & b);
      op_xor:    full = int'(a ^ b);
      op_load_b: full = ib;
      op_add:    full = ia + ib;
      op_sub:    full = ia - ib;
      op_adc:    full = ia + ib + ic;
      op_sbb:    full = ia - ib - ic;
      default:   full = 0;
    endcase
    case (op)
      op_lsr, op_ror: xbit = a[0];       // bit shifted out at the bottom
      op_sub, op_sbb: xbit = (full < 0);  // borrow
      default:        xbit = (full >= (1 << WIDTH));
    endcase
    low       = full[WIDTH-1:0];
    carry_out = op[2] ? xbit : cin;
    exp_y_q.push_back(low);
    exp_flags_q.push_back({carry_out, low == '0, low[WIDTH-1]});
    exp_dest_q.push_back(dest);
    name_q.push_back(name);
  endtask

  task automatic drive_command(input logic [15:0] word, input logic [WIDTH-1:0] a,
                               input logic [WIDTH-1:0] b, input logic cin);
    @(posedge clk);
    in_req   <= 1'b1;
    in_instr <= word;
    in_a     <= a;
    in_b     <= b;
    in_carry <= cin;
    do @(posedge clk); while (!in_ack);
    in_req <= 1'b0;
    do @(posedge clk); while (in_ack);
  endtask

  task automatic issue_random_command(input int n);
    logic [15:0]      r;
    logic [15:0]      s;
    int               form;
    logic [3:0]       op;
    logic [2:0]       dest;
    logic [WIDTH-1:0] a;
    logic [WIDTH-1:0] b;
    logic [WIDTH-1:0] b_pin;
    logic [7:0]       imm;
    logic             cin;
    logic [15:0]      word;
    r     = lcg_next(stim_state);
    s     = lcg_next(stim_state);
    a     = lcg_next(stim_state);
    b     = lcg_next(stim_state);
    b_pin = b;
    cin   = r[8];
    dest  = r[11:9];
    form  = (n < 16) ? 0 : int'(r[2:0]);  // 0..2 reg, 3..5 imm, 6..7 illegal
    op    = (n < 16) ? n[3:0] : r[15:12];  // first sixteen sweep every op
    case (r[5:4])
      2'd0: b = a;     // sub, xor give zero
      2'd1: a = '0;
      2'd2: a = '1;    // inc wraps to zero
      default: ;
    endcase
    if (form < 3) begin
      b_pin = b;
      word  = {5'b00000, dest, 1'b0, op, s[2:0]};
      push_expected($sformatf("cmd%0d reg op%0d", n, op), op, a, b, cin, dest);
    end else if (form < 6) begin
      imm  = (r[5:4] == 2'd0) ? a[7:0] : s[10:3];
      if (r[5:4] == 2'd0) a = WIDTH'(imm);
      op   = {1'b1, r[14:12]};
      word = {2'b11, op[2:0], dest, imm};
      b    = WIDTH'(imm);                  // in_b pin stays random and is ignored
      push_expected($sformatf("cmd%0d imm op%0d", n, op), op, a, b, cin, dest);
    end else begin
      case (s[1:0])
        2'd0:    word = {2'b01, s[15:2]};
        2'd1:    word = {2'b10, s[15:2]};
        default: word = {5'b00000, dest, 1'b1, s[6:0]};  // reg form with bit 7 set
      endcase
    end
    repeat (int'(s[13:12])) @(posedge clk);
    drive_command(word, a, b_pin, cin);
  endtask

  initial begin : run_commands
    reset    = 1'b1;
    in_req   = 1'b0;
    in_instr = '0;
    in_a     = '0;
    in_b     = '0;
    in_carry = 1'b0;
    out_ack  = 1'b0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    for (int n = 0; n < NUM_CMDS; n++) issue_random_command(n);
    while (exp_y_q.size() != 0) @(posedge clk);
    repeat (40) @(posedge clk);  // longest out_ack delay plus room for a stray result
    if (out_req || in_ack)
      stop_with_failure("ports not idle at the end of the run");
    else begin
      $display("test passed");
      $finish;
    end
  end

  initial begin : receive_results
    logic [15:0] r;
    int          delay;
    @(negedge reset);
    forever begin
      @(posedge clk);
      if (out_req) begin
        if (exp_y_q.size() == 0)
          stop_with_failure("a result arrived with no command outstanding");
        check_value(name_q[0], exp_y_q[0], out_y);
        check_flags(name_q[0], exp_flags_q[0], {out_carry, out_zero, out_neg});
        check_dest(name_q[0], exp_dest_q[0], out_dest);
        void'(exp_y_q.pop_front());
        void'(exp_flags_q.pop_front());
        void'(exp_dest_q.pop_front());
        void'(name_q.pop_front());
        r     = lcg_next(ack_state);
        delay = r[4] ? 10 + int'(r[3:0]) : int'(r[1:0]);  // long waits fill the lanes
        repeat (delay) @(posedge clk);
        out_ack <= 1'b1;
        do @(posedge clk); while (out_req);
        out_ack <= 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > CYCLE_LIMIT)
      stop_with_failure($sformatf("timeout, run not finished after %0d cycles", CYCLE_LIMIT));
  end

endmodule

// ==== all.f ====
alu_pkg.sv
lane_if.sv
alu_dispatch.sv
alu_lane.sv
alu_collect.sv
alu_array_top.sv
alu_array_properties.sv
tb_alu_array.sv

// ==== Makefile ====
# Verilator build and run of the ALU lane array testbench

BUILD = obj_dir
LOG   = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_alu_array \
	  --Mdir $(BUILD) -o sim -f all.f
	./$(BUILD)/sim 2>&1 | tee $(LOG)
	@if grep -q "test passed" $(LOG); then \
	  echo "simulation PASSED"; \
	else \
	  echo "simulation FAILED, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
